// File: filelist.f
design/rvDecodePkg.sv
design/instrDecoder.sv
design/decodeStage.sv
design/regFile.sv
design/regReadStage.sv
design/dualIssueFrontEnd.sv
sim/frontEndTb_chk.sv
sim/frontEndTb.sv

// File: Bender.yml
package:
  name: dual_issue_front_end

sources:
  - design/rvDecodePkg.sv
  - design/instrDecoder.sv
  - design/decodeStage.sv
  - design/regFile.sv
  - design/regReadStage.sv
  - design/dualIssueFrontEnd.sv
  - target: simulation
    files:
      - sim/frontEndTb_chk.sv
      - sim/frontEndTb.sv

// File: sim/frontEndTb.sv
`timescale 1ns/1ps

module frontEndTb;

    logic                   clk = 1'b0;
    logic                   rstN;
    rvDecodePkg::instrPairT inPair;
    logic                   inValid;
    logic                   inReady;
    rvDecodePkg::wrPortT    wrPort0;
    rvDecodePkg::wrPortT    wrPort1;
    rvDecodePkg::laneOutT   outLane0;
    rvDecodePkg::laneOutT   outLane1;
    logic                   outValid;
    logic                   outReady;

    int                     cycles = 0;
    int                     errors = 0;
    int                     tests = 0;
    logic [31:0]            lfsr = 32'h5860dc08;
    rvDecodePkg::xlenT      model [32]; // expected register contents

    dualIssueFrontEnd dut_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin // all tests need a few hundred cycles
            $display("timeout: the tests did not complete within 2000 cycles");
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic rvDecodePkg::xlenT randWord();
        rvDecodePkg::xlenT v;
        v = '0;
        for (int b = 0; b < 64; b++) begin
            lfsr = lfsrStep(lfsr); // one step per bit
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rvDecodePkg::instrT rType(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic rvDecodePkg::instrT iType(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rvDecodePkg::ctrlT mkCtrl(input logic rw, input logic [1:0] res,
            input logic [4:0] ms, input logic [5:0] op, input logic src,
            input rvDecodePkg::xlenT imm, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [4:0] rd, input logic j, input logic b, input logic e);
        return '{regWrite: rw, resultSrc: res, memSize: ms, aluOp: op, aluSrc: src, imm: imm,
                 rs1: rs1, rs2: rs2, rd: rd, jump: j, branch: b, ecall: e};
    endfunction

    task automatic checkVal(input string name, input logic [255:0] exp, input logic [255:0] got);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        tests++;
        $display("test %s: %s", name, (errors == errBefore) ? "ok" : "FAILED");
    endtask

    task automatic sendPair(input rvDecodePkg::instrT i0, input rvDecodePkg::instrT i1,
            output int acc);
        logic ok;
        inPair = '{instr1: i1, instr0: i0};
        inValid = 1'b1;
        do begin
            @(negedge clk);
            ok = inReady;
            acc = cycles + 1; // transfer lands on the next edge
            @(posedge clk);
            #1;
        end while (!ok);
        inValid = 1'b0;
    endtask

    task automatic recvPair(output rvDecodePkg::laneOutT l0, output rvDecodePkg::laneOutT l1,
            output int cyc);
        outReady = 1'b1;
        do @(negedge clk); while (!outValid);
        l0 = outLane0;
        l1 = outLane1;
        cyc = cycles + 1; // taken on the next edge
        @(posedge clk);
        #1;
    endtask

    task automatic writeCycle(input logic [4:0] rd0, input logic [4:0] rd1);
        wrPort0 = '{en: 1'b1, rd: rd0, data: randWord()};
        wrPort1 = '{en: 1'b1, rd: rd1, data: randWord()};
        if (rd0 != 0) model[rd0] = wrPort0.data;
        if (rd1 != 0) model[rd1] = wrPort1.data; // port 1 wins a shared rd
        @(posedge clk);
        #1;
        wrPort0.en = 1'b0;
        wrPort1.en = 1'b0;
    endtask

    task automatic readPair(input logic [4:0] a, input logic [4:0] b, input logic [4:0] c,
            input logic [4:0] d);
        rvDecodePkg::laneOutT l0;
        rvDecodePkg::laneOutT l1;
        int acc;
        int cyc;
        sendPair(rType(7'h00, b, a, 3'd0, 5'd10, 7'b0110011),
                 rType(7'h00, d, c, 3'd0, 5'd11, 7'b0110011), acc);
        recvPair(l0, l1, cyc);
        checkVal("outLane0.rd1Data", model[a], l0.rd1Data);
        checkVal("outLane0.rd2Data", model[b], l0.rd2Data);
        checkVal("outLane1.rd1Data", model[c], l1.rd1Data);
        checkVal("outLane1.rd2Data", model[d], l1.rd2Data);
    endtask

    task automatic resetTest();
        int e0;
        e0 = errors;
        @(negedge clk);
        checkVal("outValid", 1'b0, outValid);
        checkVal("inReady", 1'b1, inReady);
        @(posedge clk);
        #1;
        reportTest("reset", e0);
    endtask

    task automatic decodeTest();
        rvDecodePkg::instrT instrTab [18];
        rvDecodePkg::ctrlT  expTab [18];
        rvDecodePkg::laneOutT l0;
        rvDecodePkg::laneOutT l1;
        int e0;
        int acc;
        int cyc;
        e0 = errors;
        instrTab[0]  = rType(7'h00, 7, 6, 3'd0, 5, 7'b0110011);      // add x5,x6,x7
        instrTab[1]  = rType(7'h01, 7, 6, 3'd0, 5, 7'b0110011);      // mul
        instrTab[2]  = rType(7'h20, 7, 6, 3'd0, 5, 7'b0110011);      // sub
        instrTab[3]  = iType(12'hffd, 6, 3'd0, 5, 7'b0010011);       // addi -3
        instrTab[4]  = iType(12'h405, 6, 3'd5, 5, 7'b0010011);       // srai 5
        instrTab[5]  = iType(12'd7, 6, 3'd0, 5, 7'b0011011);         // addiw 7
        instrTab[6]  = rType(7'h20, 7, 6, 3'd5, 5, 7'b0111011);      // sraw
        instrTab[7]  = iType(12'd16, 6, 3'd3, 5, 7'b0000011);        // ld 16(x6)
        instrTab[8]  = rType(7'h7f, 7, 6, 3'd3, 5'b11000, 7'b0100011); // sd -8(x6)
        instrTab[9]  = rType(7'h00, 7, 6, 3'd0, 5'b10000, 7'b1100011); // beq +16
        instrTab[10] = rType(7'h7f, 7, 6, 3'd7, 5'b11101, 7'b1100011); // bgeu -4
        instrTab[11] = {20'h12345, 5'd5, 7'b0110111};                // lui
        instrTab[12] = {20'h80000, 5'd5, 7'b0010111};                // auipc
        instrTab[13] = {1'b0, 10'd0, 1'b1, 8'd0, 5'd1, 7'b1101111};  // jal +2048
        instrTab[14] = iType(12'd4, 6, 3'd0, 1, 7'b1100111);         // jalr 4(x6)
        instrTab[15] = 32'h00000073;                                 // ecall
        instrTab[16] = 32'hffffffff;                                 // unknown opcode
        instrTab[17] = iType(12'd0, 0, 3'd0, 0, 7'b0010011);         // nop
        expTab[0]  = mkCtrl(1, 0, 0, 4, 0, 0, 6, 7, 5, 0, 0, 0);
        expTab[1]  = mkCtrl(1, 0, 0, 10, 0, 0, 6, 7, 5, 0, 0, 0);
        expTab[2]  = mkCtrl(1, 0, 0, 5, 0, 0, 6, 7, 5, 0, 0, 0);
        expTab[3]  = mkCtrl(1, 0, 0, 4, 1, 64'hffff_ffff_ffff_fffd, 6, 0, 5, 0, 0, 0);
        expTab[4]  = mkCtrl(1, 0, 0, 3, 1, 64'h405, 6, 0, 5, 0, 0, 0);
        expTab[5]  = mkCtrl(1, 0, 0, 36, 1, 7, 6, 0, 5, 0, 0, 0);
        expTab[6]  = mkCtrl(1, 0, 0, 35, 0, 0, 6, 7, 5, 0, 0, 0);
        expTab[7]  = mkCtrl(1, 1, 5'b01011, 4, 1, 16, 6, 0, 5, 0, 0, 0);
        expTab[8]  = mkCtrl(0, 0, 5'b10011, 4, 1, 64'hffff_ffff_ffff_fff8, 6, 7, 24, 0, 0, 0);
        expTab[9]  = mkCtrl(0, 0, 0, 23, 0, 16, 6, 7, 0, 0, 1, 0);
        expTab[10] = mkCtrl(0, 0, 0, 28, 0, 64'hffff_ffff_ffff_fffc, 6, 7, 0, 0, 1, 0);
        expTab[11] = mkCtrl(1, 0, 0, 20, 1, 64'h1234_5000, 0, 0, 5, 0, 0, 0);
        expTab[12] = mkCtrl(1, 0, 0, 19, 1, 64'hffff_ffff_8000_0000, 0, 0, 5, 0, 0, 0);
        expTab[13] = mkCtrl(1, 2, 0, 22, 1, 2048, 0, 0, 1, 1, 0, 0);
        expTab[14] = mkCtrl(1, 2, 0, 21, 1, 4, 6, 0, 1, 1, 0, 0);
        expTab[15] = mkCtrl(0, 0, 0, 29, 0, 0, 0, 0, 0, 0, 0, 1);
        expTab[16] = '0;
        expTab[17] = mkCtrl(1, 0, 0, 4, 1, 0, 0, 0, 0, 0, 0, 0);
        for (int i = 0; i < 9; i++) begin
            sendPair(instrTab[2*i], instrTab[2*i+1], acc);
            recvPair(l0, l1, cyc);
            checkVal($sformatf("outLane0.ctrl[%0d]", 2*i), expTab[2*i], l0.ctrl);
            checkVal($sformatf("outLane1.ctrl[%0d]", 2*i+1), expTab[2*i+1], l1.ctrl);
        end
        reportTest("decode", e0);
    endtask

    task automatic readTest();
        int e0;
        e0 = errors;
        for (int k = 0; k < 3; k++) begin
            writeCycle(5'(2*k+1), 5'(2*k+2));
        end
        writeCycle(5'd0, 5'd7); // x0 write must be dropped
        @(posedge clk);
        #1;
        readPair(1, 2, 3, 4);
        readPair(5, 6, 0, 7);
        reportTest("register read", e0);
    endtask

    task automatic conflictTest();
        int e0;
        e0 = errors;
        writeCycle(5'd9, 5'd9);
        @(posedge clk);
        #1;
        readPair(9, 9, 0, 9);
        reportTest("same rd conflict", e0);
    endtask

    task automatic stallTest();
        rvDecodePkg::laneOutT snap0;
        rvDecodePkg::laneOutT snap1;
        rvDecodePkg::laneOutT l0;
        rvDecodePkg::laneOutT l1;
        int e0;
        int acc;
        int cyc;
        e0 = errors;
        outReady = 1'b0;
        for (int k = 0; k < 2; k++) begin
            sendPair(iType(12'(2*k+1), 0, 0, 1, 7'b0010011),
                     iType(12'(2*k+2), 0, 0, 2, 7'b0010011), acc);
        end
        @(negedge clk);
        checkVal("inReady", 1'b0, inReady); // both stages full
        snap0 = outLane0;
        snap1 = outLane1;
        repeat (3) begin
            @(negedge clk);
            checkVal("outLane0", snap0, outLane0);
            checkVal("outLane1", snap1, outLane1);
        end
        @(posedge clk);
        #1;
        fork
            sendPair(iType(12'd5, 0, 0, 1, 7'b0010011), iType(12'd6, 0, 0, 2, 7'b0010011), acc);
            for (int k = 0; k < 3; k++) begin
                recvPair(l0, l1, cyc);
                checkVal("outLane0.ctrl.imm", 2*k+1, l0.ctrl.imm);
                checkVal("outLane1.ctrl.imm", 2*k+2, l1.ctrl.imm);
            end
        join
        reportTest("back-pressure", e0);
    endtask

    task automatic throughputTest();
        rvDecodePkg::laneOutT l0;
        rvDecodePkg::laneOutT l1;
        int accCyc [4];
        int outCyc [4];
        int e0;
        e0 = errors;
        outReady = 1'b1;
        fork
            for (int k = 0; k < 4; k++) begin
                sendPair(iType(12'(10+2*k), 0, 0, 1, 7'b0010011),
                         iType(12'(11+2*k), 0, 0, 2, 7'b0010011), accCyc[k]);
            end
            for (int k = 0; k < 4; k++) begin
                recvPair(l0, l1, outCyc[k]);
                checkVal("outLane0.ctrl.imm", 10+2*k, l0.ctrl.imm);
                checkVal("outLane1.ctrl.imm", 11+2*k, l1.ctrl.imm);
            end
        join
        for (int k = 0; k < 4; k++) begin
            checkVal("latency", 2, outCyc[k] - accCyc[k]);
        end
        reportTest("throughput", e0);
    endtask

    initial begin
        rstN = 1'b0;
        inValid = 1'b0;
        inPair = '0;
        outReady = 1'b0;
        wrPort0 = '0;
        wrPort1 = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        resetTest();
        decodeTest();
        readTest();
        conflictTest();
        stallTest();
        throughputTest();
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: sim/frontEndTb_chk.sv
`timescale 1ns/1ps

module frontEndChk (
    input logic                                               clk,
    input logic                                               rstN,
    input logic                                               outValid,
    input logic                                               outReady,
    input rvDecodePkg::laneOutT                               outLane0,
    input rvDecodePkg::laneOutT                               outLane1,
    input rvDecodePkg::regAddrT [rvDecodePkg::NumRdPorts-1:0] rdAddr,
    input rvDecodePkg::xlenT    [rvDecodePkg::NumRdPorts-1:0] rdData
);

    // held output must not change until taken
    stallHold: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outLane0) && $stable(outLane1))
        else $error("output changed or dropped while stalled");

    resetLow: assert property (@(posedge clk) !rstN |=> !outValid)
        else $error("outValid high during reset");

    for (genvar p = 0; p < rvDecodePkg::NumRdPorts; p++) begin : g_x0
        x0Zero: assert property (@(posedge clk) rdAddr[p] == '0 |-> rdData[p] == '0)
            else $error("read of x0 returned nonzero on port %0d", p);
    end

endmodule

bind dualIssueFrontEnd frontEndChk chk_i (
    .clk, .rstN, .outValid, .outReady, .outLane0, .outLane1, .rdAddr, .rdData
);

// File: design/dualIssueFrontEnd.sv
`timescale 1ns/1ps

module dualIssueFrontEnd (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvDecodePkg::instrPairT inPair,
    input  logic                   inValid,
    output logic                   inReady,
    input  rvDecodePkg::wrPortT    wrPort0,
    input  rvDecodePkg::wrPortT    wrPort1,
    output rvDecodePkg::laneOutT   outLane0,
    output rvDecodePkg::laneOutT   outLane1,
    output logic                   outValid,
    input  logic                   outReady
);

    rvDecodePkg::ctrlT                               decCtrl0;
    rvDecodePkg::ctrlT                               decCtrl1;
    logic                                            decValid;
    logic                                            decReady;
    rvDecodePkg::regAddrT [rvDecodePkg::NumRdPorts-1:0] rdAddr;
    rvDecodePkg::xlenT    [rvDecodePkg::NumRdPorts-1:0] rdData;

    // port order: lane0 rs1, lane0 rs2, lane1 rs1, lane1 rs2
    assign rdAddr = {decCtrl1.rs2, decCtrl1.rs1, decCtrl0.rs2, decCtrl0.rs1};

    decodeStage decode_i (
        .clk, .rstN, .inPair, .inValid, .inReady,
        .decCtrl0, .decCtrl1, .decValid, .decReady
    );

    regFile regs_i (.clk, .rstN, .wrPort0, .wrPort1, .rdAddr, .rdData);

    regReadStage read_i (
        .clk, .rstN, .decCtrl0, .decCtrl1, .decValid, .decReady,
        .rdData, .outLane0, .outLane1, .outValid, .outReady
    );

endmodule

// File: design/regReadStage.sv
`timescale 1ns/1ps

module regReadStage (
    input  logic                                        clk,
    input  logic                                        rstN,
    input  rvDecodePkg::ctrlT                           decCtrl0,
    input  rvDecodePkg::ctrlT                           decCtrl1,
    input  logic                                        decValid,
    output logic                                        decReady,
    input  rvDecodePkg::xlenT [rvDecodePkg::NumRdPorts-1:0] rdData,
    output rvDecodePkg::laneOutT                        outLane0,
    output rvDecodePkg::laneOutT                        outLane1,
    output logic                                        outValid,
    input  logic                                        outReady
);

    rvDecodePkg::laneOutT lane0Q;
    rvDecodePkg::laneOutT lane1Q;
    logic                 validQ;
    logic                 accept;

    assign decReady = !validQ || outReady;
    assign accept   = decValid && decReady;
    assign outValid = validQ;
    assign outLane0 = lane0Q;
    assign outLane1 = lane1Q;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (accept) begin
            validQ <= 1'b1;
        end else if (outReady) begin
            validQ <= 1'b0;
        end
    end

    // operands sampled once, on entry; a stall keeps them as read
    always_ff @(posedge clk) begin
        if (accept) begin
            lane0Q <= '{ctrl: decCtrl0, rd1Data: rdData[0], rd2Data: rdData[1]};
            lane1Q <= '{ctrl: decCtrl1, rd1Data: rdData[2], rd2Data: rdData[3]};
        end
    end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                                           clk,
    input  logic                                           rstN,
    input  rvDecodePkg::wrPortT                            wrPort0,
    input  rvDecodePkg::wrPortT                            wrPort1,
    input  rvDecodePkg::regAddrT [rvDecodePkg::NumRdPorts-1:0] rdAddr,
    output rvDecodePkg::xlenT    [rvDecodePkg::NumRdPorts-1:0] rdData
);

    rvDecodePkg::xlenT regs [rvDecodePkg::NumRegs];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < rvDecodePkg::NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrPort0.en && wrPort0.rd != '0) begin
                regs[wrPort0.rd] <= wrPort0.data;
            end
            // port 1 comes last so it wins on a shared rd
            if (wrPort1.en && wrPort1.rd != '0) begin
                regs[wrPort1.rd] <= wrPort1.data;
            end
        end
    end

    // async read, no bypass from the write ports
    always_comb begin
        for (int p = 0; p < rvDecodePkg::NumRdPorts; p++) begin
            if (rdAddr[p] == '0) begin
                rdData[p] = '0; // x0
            end else begin
                rdData[p] = regs[rdAddr[p]];
            end
        end
    end

endmodule

// File: design/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvDecodePkg::instrPairT inPair,
    input  logic                   inValid,
    output logic                   inReady,
    output rvDecodePkg::ctrlT      decCtrl0,
    output rvDecodePkg::ctrlT      decCtrl1,
    output logic                   decValid,
    input  logic                   decReady
);

    rvDecodePkg::instrPairT pairQ;
    logic                   validQ;
    logic                   accept;

    assign inReady  = !validQ || decReady; // empty, or the held pair moves on
    assign accept   = inValid && inReady;
    assign decValid = validQ;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (accept) begin
            validQ <= 1'b1;
        end else if (decReady) begin
            validQ <= 1'b0; // drained without refill
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pairQ <= inPair;
        end
    end

    // decode from the held pair so rs1/rs2 feed the register file directly
    instrDecoder dec0_i (.instr(pairQ.instr0), .ctrl(decCtrl0));
    instrDecoder dec1_i (.instr(pairQ.instr1), .ctrl(decCtrl1));

endmodule

// File: design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  rvDecodePkg::instrT instr,
    output rvDecodePkg::ctrlT  ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rvDecodePkg::xlenT immI;
    rvDecodePkg::xlenT immS;
    rvDecodePkg::xlenT immB;
    rvDecodePkg::xlenT immU;
    rvDecodePkg::xlenT immJ;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign-extended immediate formats
    assign immI = {{52{instr[31]}}, instr[31:20]};
    assign immS = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign immJ = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0; // unknown opcode leaves everything clear
        case (opcode)
            rvDecodePkg::OpLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = rvDecodePkg::ResMem;
                ctrl.memSize   = {rvDecodePkg::MemLoad, funct3};
                ctrl.aluSrc    = 1'b1;
                ctrl.imm       = immI;
                ctrl.rs1       = instr[19:15];
                ctrl.rd        = instr[11:7];
                ctrl.aluOp     = rvDecodePkg::AluAdd; // address calc
            end
            rvDecodePkg::OpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immI;
                ctrl.rs1      = instr[19:15];
                ctrl.rd       = instr[11:7];
                case (funct3)
                    3'b000: ctrl.aluOp = rvDecodePkg::AluAdd;
                    3'b001: ctrl.aluOp = rvDecodePkg::AluSll;
                    3'b010: ctrl.aluOp = rvDecodePkg::AluSlt;
                    3'b011: ctrl.aluOp = rvDecodePkg::AluSltu;
                    3'b100: ctrl.aluOp = rvDecodePkg::AluXor;
                    3'b101: begin
                        // shamt is 6 bits on RV64, so only [31:26] selects
                        if (instr[31:26] == 6'b000000) ctrl.aluOp = rvDecodePkg::AluSrl;
                        if (instr[31:26] == 6'b010000) ctrl.aluOp = rvDecodePkg::AluSra;
                    end
                    3'b110: ctrl.aluOp = rvDecodePkg::AluOr;
                    default: ctrl.aluOp = rvDecodePkg::AluAnd;
                endcase
            end
            rvDecodePkg::OpAuipc, rvDecodePkg::OpLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immU;
                ctrl.rd       = instr[11:7];
                ctrl.aluOp    = (opcode == rvDecodePkg::OpLui) ? rvDecodePkg::AluLui
                                                               : rvDecodePkg::AluAuipc;
            end
            rvDecodePkg::OpImmW: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immI;
                ctrl.rs1      = instr[19:15];
                ctrl.rd       = instr[11:7];
                case ({funct7, funct3})
                    {7'b0000000, 3'b101}: ctrl.aluOp = rvDecodePkg::AluSrlw;
                    {7'b0100000, 3'b101}: ctrl.aluOp = rvDecodePkg::AluSraw;
                    default: begin
                        if (funct3 == 3'b000) ctrl.aluOp = rvDecodePkg::AluAddw;
                        if (funct3 == 3'b001) ctrl.aluOp = rvDecodePkg::AluSllw;
                    end
                endcase
            end
            rvDecodePkg::OpStore: begin
                ctrl.memSize = {rvDecodePkg::MemStore, funct3};
                ctrl.aluSrc  = 1'b1;
                ctrl.imm     = immS;
                ctrl.rs1     = instr[19:15];
                ctrl.rs2     = instr[24:20];
                ctrl.rd      = instr[11:7]; // carries imm bits, regWrite stays low
                ctrl.aluOp   = rvDecodePkg::AluAdd;
            end
            rvDecodePkg::OpReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.rs1      = instr[19:15];
                ctrl.rs2      = instr[24:20];
                ctrl.rd       = instr[11:7];
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.aluOp = rvDecodePkg::AluAdd;
                    {7'b0100000, 3'b000}: ctrl.aluOp = rvDecodePkg::AluSub;
                    {7'b0000000, 3'b001}: ctrl.aluOp = rvDecodePkg::AluSll;
                    {7'b0000000, 3'b010}: ctrl.aluOp = rvDecodePkg::AluSlt;
                    {7'b0000000, 3'b011}: ctrl.aluOp = rvDecodePkg::AluSltu;
                    {7'b0000000, 3'b100}: ctrl.aluOp = rvDecodePkg::AluXor;
                    {7'b0000000, 3'b101}: ctrl.aluOp = rvDecodePkg::AluSrl;
                    {7'b0100000, 3'b101}: ctrl.aluOp = rvDecodePkg::AluSra;
                    {7'b0000000, 3'b110}: ctrl.aluOp = rvDecodePkg::AluOr;
                    {7'b0000000, 3'b111}: ctrl.aluOp = rvDecodePkg::AluAnd;
                    {7'b0000001, 3'b000}: ctrl.aluOp = rvDecodePkg::AluMul;
                    {7'b0000001, 3'b001}: ctrl.aluOp = rvDecodePkg::AluMulh;
                    {7'b0000001, 3'b010}: ctrl.aluOp = rvDecodePkg::AluMulhsu;
                    {7'b0000001, 3'b011}: ctrl.aluOp = rvDecodePkg::AluMulhu;
                    {7'b0000001, 3'b100}: ctrl.aluOp = rvDecodePkg::AluDiv;
                    {7'b0000001, 3'b101}: ctrl.aluOp = rvDecodePkg::AluDivu;
                    {7'b0000001, 3'b110}: ctrl.aluOp = rvDecodePkg::AluRem;
                    {7'b0000001, 3'b111}: ctrl.aluOp = rvDecodePkg::AluRemu;
                    default: ;
                endcase
            end
            rvDecodePkg::OpRegW: begin
                ctrl.regWrite = 1'b1;
                ctrl.rs1      = instr[19:15];
                ctrl.rs2      = instr[24:20];
                ctrl.rd       = instr[11:7];
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.aluOp = rvDecodePkg::AluAddw;
                    {7'b0000001, 3'b000}: ctrl.aluOp = rvDecodePkg::AluMulw;
                    {7'b0100000, 3'b000}: ctrl.aluOp = rvDecodePkg::AluSubw;
                    {7'b0000000, 3'b101}: ctrl.aluOp = rvDecodePkg::AluSrlw;
                    {7'b0000001, 3'b101}: ctrl.aluOp = rvDecodePkg::AluDivuw;
                    {7'b0100000, 3'b101}: ctrl.aluOp = rvDecodePkg::AluSraw;
                    default: begin
                        // these funct3 values ignore funct7
                        if (funct3 == 3'b001) ctrl.aluOp = rvDecodePkg::AluSllw;
                        if (funct3 == 3'b100) ctrl.aluOp = rvDecodePkg::AluDivw;
                        if (funct3 == 3'b110) ctrl.aluOp = rvDecodePkg::AluRemw;
                        if (funct3 == 3'b111) ctrl.aluOp = rvDecodePkg::AluRemuw;
                    end
                endcase
            end
            rvDecodePkg::OpBranch: begin
                ctrl.branch = 1'b1;
                ctrl.imm    = immB;
                ctrl.rs1    = instr[19:15];
                ctrl.rs2    = instr[24:20];
                case (funct3)
                    3'b000: ctrl.aluOp = rvDecodePkg::AluBeq;
                    3'b001: ctrl.aluOp = rvDecodePkg::AluBne;
                    3'b100: ctrl.aluOp = rvDecodePkg::AluBlt;
                    3'b101: ctrl.aluOp = rvDecodePkg::AluBge;
                    3'b110: ctrl.aluOp = rvDecodePkg::AluBltu;
                    3'b111: ctrl.aluOp = rvDecodePkg::AluBgeu;
                    default: ;
                endcase
            end
            rvDecodePkg::OpJalr, rvDecodePkg::OpJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = rvDecodePkg::ResPc4; // link value
                ctrl.jump      = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.rd        = instr[11:7];
                if (opcode == rvDecodePkg::OpJalr) begin
                    ctrl.imm   = immI;
                    ctrl.rs1   = instr[19:15];
                    ctrl.aluOp = rvDecodePkg::AluJalr;
                end else begin
                    ctrl.imm   = immJ;
                    ctrl.aluOp = rvDecodePkg::AluJal;
                end
            end
            rvDecodePkg::OpSystem: begin
                if (funct3 == 3'b000 && instr[31:20] == 12'h000) begin
                    ctrl.ecall = 1'b1;
                    ctrl.aluOp = rvDecodePkg::AluEcall;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: design/rvDecodePkg.sv
package rvDecodePkg;

    localparam int XLEN       = 64;
    localparam int NumLanes   = 2;
    localparam int RegAddrW   = 5;
    localparam int NumRegs    = 1 << RegAddrW;
    localparam int NumRdPorts = 2 * NumLanes; // rs1 and rs2 per lane

    typedef logic [XLEN-1:0]     xlenT;
    typedef logic [31:0]         instrT;
    typedef logic [RegAddrW-1:0] regAddrT;
    typedef logic [5:0]          aluOpT;
    typedef logic [4:0]          memSizeT;  // {kind, funct3}
    typedef logic [1:0]          resultSrcT;

    localparam resultSrcT ResAlu = 2'd0;
    localparam resultSrcT ResMem = 2'd1;
    localparam resultSrcT ResPc4 = 2'd2;

    localparam logic [1:0] MemLoad  = 2'b01; // top bits of memSize
    localparam logic [1:0] MemStore = 2'b10;

    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpImm    = 7'b0010011;
    localparam logic [6:0] OpAuipc  = 7'b0010111;
    localparam logic [6:0] OpLui    = 7'b0110111;
    localparam logic [6:0] OpImmW   = 7'b0011011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpReg    = 7'b0110011;
    localparam logic [6:0] OpRegW   = 7'b0111011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpSystem = 7'b1110011;

    localparam aluOpT AluSll = 6'd1, AluSrl = 6'd2, AluSra = 6'd3, AluAdd = 6'd4, AluSub = 6'd5;
    localparam aluOpT AluDiv = 6'd6, AluDivu = 6'd7, AluRem = 6'd8, AluRemu = 6'd9;
    localparam aluOpT AluMul = 6'd10, AluMulh = 6'd11, AluMulhu = 6'd12, AluMulhsu = 6'd13;
    localparam aluOpT AluXor = 6'd14, AluOr = 6'd15, AluAnd = 6'd16;
    localparam aluOpT AluSlt = 6'd17, AluSltu = 6'd18;
    localparam aluOpT AluAuipc = 6'd19, AluLui = 6'd20, AluJalr = 6'd21, AluJal = 6'd22;
    localparam aluOpT AluBeq = 6'd23, AluBne = 6'd24, AluBlt = 6'd25, AluBge = 6'd26;
    localparam aluOpT AluBltu = 6'd27, AluBgeu = 6'd28;
    localparam aluOpT AluEcall = 6'd29;
    localparam aluOpT AluSllw = 6'd33, AluSrlw = 6'd34, AluSraw = 6'd35, AluAddw = 6'd36;
    localparam aluOpT AluSubw = 6'd37, AluDivw = 6'd38, AluDivuw = 6'd39, AluRemw = 6'd40;
    localparam aluOpT AluRemuw = 6'd41, AluMulw = 6'd42;

    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        memSizeT   memSize;
        aluOpT     aluOp;
        logic      aluSrc;    // immediate as second operand
        xlenT      imm;
        regAddrT   rs1;
        regAddrT   rs2;
        regAddrT   rd;
        logic      jump;
        logic      branch;
        logic      ecall;
    } ctrlT;

    typedef struct packed {
        instrT instr1;
        instrT instr0; // lane 0 sits in the low half
    } instrPairT;

    typedef struct packed {
        ctrlT ctrl;
        xlenT rd1Data;
        xlenT rd2Data;
    } laneOutT;

    typedef struct packed {
        logic    en;
        regAddrT rd;
        xlenT    data;
    } wrPortT;

endpackage
